/* logic/vsp_pkg.sv */
//****************************************
// vsp_pkg
// widths, region geometry, register map,
// colours and the 8x16 digit font
//****************************************
package vsp_pkg;

    localparam int pix_w   = 16;   // RGB565 word
    localparam int gray_w  = 8;
    localparam int coord_w = 10;   // column or line index

    // region of interest
    localparam int roi_size   = 28;   // interior side
    localparam int roi_border = 2;    // ring around the interior

    localparam logic [pix_w-1:0]  red565      = 16'hF800;
    localparam logic [pix_w-1:0]  ink565      = 16'hFFFF;
    localparam logic [gray_w-1:0] fcnn_marker = 8'hFF;   // end of block for the classifier

    // digit cell
    localparam int glyph_w = 8;
    localparam int glyph_h = 16;

    // one byte per row, row 0 first, bit 7 is the leftmost column
    localparam logic [0:9][0:glyph_h-1][glyph_w-1:0] font_rows = {
        128'h00007CC6C6CEDEF6E6C6C67C00000000,   // 0
        128'h00001838781818181818187E00000000,   // 1
        128'h00007CC6060C183060C0C6FE00000000,   // 2
        128'h00007CC606063C060606C67C00000000,   // 3
        128'h00000C1C3C6CCCFE0C0C0C1E00000000,   // 4
        128'h0000FEC0C0C0FC060606C67C00000000,   // 5
        128'h00003860C0C0FCC6C6C6C67C00000000,   // 6
        128'h0000FEC606060C183030303000000000,   // 7
        128'h00007CC6C6C67CC6C6C6C67C00000000,   // 8
        128'h00007CC6C6C67E0606060C7800000000    // 9
    };

    // register map
    localparam logic [1:0] reg_roi_x     = 2'd0;
    localparam logic [1:0] reg_roi_y     = 2'd1;
    localparam logic [1:0] reg_threshold = 2'd2;
    localparam logic [1:0] reg_digit     = 2'd3;

    localparam logic [coord_w-1:0] rst_roi_x     = 10'd16;
    localparam logic [coord_w-1:0] rst_roi_y     = 10'd10;
    localparam logic [gray_w-1:0]  rst_threshold = 8'd127;
    localparam logic [3:0]         rst_digit     = 4'd0;

endpackage

/* logic/pixel_if.sv */
//****************************************
// pixel_if
// raster pixel stream with its column and
// line tag
//****************************************
`timescale 1ns/10ps

interface pixel_if;

    logic                         vsync;
    logic                         href;
    logic [vsp_pkg::pix_w-1:0]    data;
    logic                         valid;     // one pixel per strobe
    logic [vsp_pkg::coord_w-1:0]  h_index;   // column
    logic [vsp_pkg::coord_w-1:0]  v_index;   // line

    modport src (
        output vsync, href, data, valid, h_index, v_index
    );

    modport snk (
        input vsync, href, data, valid, h_index, v_index
    );

endinterface

/* logic/roi_cfg_if.sv */
//****************************************
// roi_cfg_if
// settings from the register block to the
// overlay logic
//****************************************
`timescale 1ns/10ps

interface roi_cfg_if;

    logic [vsp_pkg::coord_w-1:0] roi_x;
    logic [vsp_pkg::coord_w-1:0] roi_y;
    logic [vsp_pkg::gray_w-1:0]  threshold;
    logic [3:0]                  digit;      // 0 to 9

    modport drv (output roi_x, roi_y, threshold, digit);
    modport rd  (input  roi_x, roi_y, threshold, digit);

endinterface

/* logic/rgb_to_gray.sv */
//****************************************
// rgb_to_gray
// two-stage RGB565 to 8-bit gray, with the
// gray value repacked as RGB565
//****************************************
`timescale 1ns/10ps

module rgb_to_gray (
    input  logic                        pclk,
    input  logic                        rst_n,
    input  logic                        pix_valid,
    input  logic [vsp_pkg::pix_w-1:0]   pix_data,
    output logic                        gray_valid,
    output logic [vsp_pkg::gray_w-1:0]  gray,
    output logic [vsp_pkg::pix_w-1:0]   gray565
);

    logic [7:0]  r8, g8, b8;          // channels widened to 8 bits
    logic [15:0] r_w, g_w, b_w;       // weighted, stage one
    logic        valid_s1;
    logic [15:0] sum;
    logic [7:0]  gray_c;

    assign r8 = {pix_data[15:11], 3'b000};
    assign g8 = {pix_data[10:5], 2'b00};
    assign b8 = {pix_data[4:0], 3'b000};

    // stage one: weights 77/150/29 out of 256
    always_ff @(posedge pclk) begin
        r_w <= 16'(r8 * 8'd77);
        g_w <= 16'(g8 * 8'd150);
        b_w <= 16'(b8 * 8'd29);
    end

    // worst case 64088, no overflow in 16 bits
    assign sum    = r_w + g_w + b_w;
    assign gray_c = sum[15:8];

    // stage two
    always_ff @(posedge pclk) begin
        gray    <= gray_c;
        gray565 <= {gray_c[7:3], gray_c[7:2], gray_c[7:3]};
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1   <= 1'b0;
            gray_valid <= 1'b0;
        end else begin
            valid_s1   <= pix_valid;
            gray_valid <= valid_s1;   // two cycles behind pix_valid
        end
    end

endmodule

/* logic/raster_counter.sv */
//****************************************
// raster_counter
// tags every pixel of the aligned stream
// with its column and line
//****************************************
`timescale 1ns/10ps

module raster_counter #(
    parameter int h_pixel = 640,
    parameter int v_pixel = 480
) (
    input  logic                       pclk,
    input  logic                       rst_n,
    input  logic                       vsync,
    input  logic                       href,
    input  logic [vsp_pkg::pix_w-1:0]  data,
    input  logic                       valid,
    pixel_if.src                       px
);

    localparam logic [vsp_pkg::coord_w-1:0] h_last = vsp_pkg::coord_w'(h_pixel - 1);
    localparam logic [vsp_pkg::coord_w-1:0] v_last = vsp_pkg::coord_w'(v_pixel - 1);

    logic [vsp_pkg::coord_w-1:0] h_cnt;
    logic [vsp_pkg::coord_w-1:0] v_cnt;
    logic                        href_d;
    logic                        line_end;

    assign line_end = href_d & ~href;   // falling edge of href

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            href_d <= 1'b0;
        end else begin
            href_d <= href;
            if (vsync) begin
                // new frame
                h_cnt <= '0;
                v_cnt <= '0;
            end else begin
                if (line_end)
                    h_cnt <= '0;
                else if (valid && h_cnt != h_last)
                    h_cnt <= h_cnt + 1'b1;   // holds at the last column

                if (line_end && v_cnt != v_last)
                    v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // stream passes straight through, tag from the counters
    assign px.vsync   = vsync;
    assign px.href    = href;
    assign px.data    = data;
    assign px.valid   = valid;
    assign px.h_index = h_cnt;
    assign px.v_index = v_cnt;

endmodule

/* logic/vsp_regs.sv */
//****************************************
// vsp_regs
// write-only settings, region position,
// threshold and shown digit
//****************************************
`timescale 1ns/10ps

module vsp_regs (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        cfg_wr,
    input  logic [1:0]  cfg_addr,
    input  logic [15:0] cfg_wdata,
    roi_cfg_if.drv      cfg
);

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.roi_x     <= vsp_pkg::rst_roi_x;
            cfg.roi_y     <= vsp_pkg::rst_roi_y;
            cfg.threshold <= vsp_pkg::rst_threshold;
            cfg.digit     <= vsp_pkg::rst_digit;
        end else if (cfg_wr) begin
            case (cfg_addr)
                vsp_pkg::reg_roi_x:     cfg.roi_x     <= cfg_wdata[vsp_pkg::coord_w-1:0];
                vsp_pkg::reg_roi_y:     cfg.roi_y     <= cfg_wdata[vsp_pkg::coord_w-1:0];
                vsp_pkg::reg_threshold: cfg.threshold <= cfg_wdata[vsp_pkg::gray_w-1:0];
                vsp_pkg::reg_digit: begin
                    // only ten glyphs in the font
                    if (cfg_wdata > 16'd9)
                        cfg.digit <= 4'd9;
                    else
                        cfg.digit <= cfg_wdata[3:0];
                end
                default: ;
            endcase
        end
    end

endmodule

/* logic/roi_overlay.sv */
//****************************************
// roi_overlay
// red square around the region, binarized
// interior and the classifier byte stream
//****************************************
`timescale 1ns/10ps

module roi_overlay (
    pixel_if.snk                        px,
    roi_cfg_if.rd                       cfg,
    input  logic [vsp_pkg::gray_w-1:0]  gray,
    input  logic                        gray_valid,
    output logic                        in_box,
    output logic [vsp_pkg::pix_w-1:0]   box_data,
    output logic                        fcnn_valid,
    output logic [vsp_pkg::gray_w-1:0]  fcnn_data
);

    // one extra bit so the far edge of the square cannot wrap
    localparam int ext_w = vsp_pkg::coord_w + 1;

    localparam logic [ext_w-1:0] int_last = ext_w'(vsp_pkg::roi_size - 1);
    localparam logic [ext_w-1:0] sq_last  = ext_w'(vsp_pkg::roi_size - 1 + vsp_pkg::roi_border);
    localparam logic [ext_w-1:0] brd      = ext_w'(vsp_pkg::roi_border);
    localparam logic [ext_w-1:0] mk_line  = ext_w'(vsp_pkg::roi_size);

    logic [ext_w-1:0] h, v, x0, y0;
    logic             in_x_int, in_y_int, in_x_sq, in_y_sq;
    logic             in_int, in_sq;
    logic             at_marker;
    logic             bin;

    assign h  = {1'b0, px.h_index};
    assign v  = {1'b0, px.v_index};
    assign x0 = {1'b0, cfg.roi_x};
    assign y0 = {1'b0, cfg.roi_y};

    // interior window
    assign in_x_int = (h >= x0) && (h <= x0 + int_last);
    assign in_y_int = (v >= y0) && (v <= y0 + int_last);

    // outer edge of the ring, left and top edge moved to the index side
    assign in_x_sq = (h + brd >= x0) && (h <= x0 + sq_last);
    assign in_y_sq = (v + brd >= y0) && (v <= y0 + sq_last);

    assign in_int = in_x_int & in_y_int;
    assign in_sq  = in_x_sq & in_y_sq;

    // last interior column, first line of the bottom border
    assign at_marker = (h == x0 + int_last) && (v == y0 + mk_line);

    assign bin = (gray <= cfg.threshold);   // dark pixels go white

    assign in_box = gray_valid & in_sq;

    always_comb begin
        if (in_int)
            box_data = {vsp_pkg::pix_w{bin}};
        else
            box_data = vsp_pkg::red565;   // border
    end

    // interior pixels plus one marker byte per frame
    assign fcnn_valid = gray_valid & (in_int | at_marker);
    assign fcnn_data  = at_marker ? vsp_pkg::fcnn_marker : {vsp_pkg::gray_w{bin}};

endmodule

/* logic/digit_glyph.sv */
//****************************************
// digit_glyph
// font lookup, marks pixels inside the
// stored digit
//****************************************
`timescale 1ns/10ps

module digit_glyph #(
    parameter int digit_x = 4,
    parameter int digit_y = 4
) (
    pixel_if.snk    px,
    roi_cfg_if.rd   cfg,
    output logic    ink
);

    localparam logic [vsp_pkg::coord_w-1:0] x0 = vsp_pkg::coord_w'(digit_x);
    localparam logic [vsp_pkg::coord_w-1:0] y0 = vsp_pkg::coord_w'(digit_y);
    localparam logic [vsp_pkg::coord_w-1:0] cw = vsp_pkg::coord_w'(vsp_pkg::glyph_w);
    localparam logic [vsp_pkg::coord_w-1:0] ch = vsp_pkg::coord_w'(vsp_pkg::glyph_h);

    logic [vsp_pkg::coord_w-1:0] dx;
    logic [vsp_pkg::coord_w-1:0] dy;
    logic                        in_cell;
    logic [vsp_pkg::glyph_w-1:0] row_bits;
    logic [vsp_pkg::glyph_w-1:0] row_shift;

    // offsets inside the cell, wrap is harmless since in_cell guards them
    assign dx = px.h_index - x0;
    assign dy = px.v_index - y0;

    assign in_cell = (px.h_index >= x0) && (dx < cw) &&
                     (px.v_index >= y0) && (dy < ch);

    assign row_bits  = vsp_pkg::font_rows[cfg.digit][dy[3:0]];
    assign row_shift = row_bits << dx[2:0];   // bit 7 is column 0

    assign ink = in_cell & row_shift[vsp_pkg::glyph_w-1];

endmodule

/* logic/video_stream_process.sv */
//****************************************
// video_stream_process
// camera front end, gray, display with
// overlays, transmit and classifier streams
//****************************************
`timescale 1ns/10ps

module video_stream_process #(
    parameter int h_pixel = 640,
    parameter int v_pixel = 480,
    parameter int digit_x = 4,
    parameter int digit_y = 4
) (
    input  logic                        pclk,
    input  logic                        rst_n,
    input  logic                        cfg_wr,
    input  logic [1:0]                  cfg_addr,
    input  logic [15:0]                 cfg_wdata,
    input  logic                        cam_vsync,
    input  logic                        cam_href,
    input  logic [vsp_pkg::pix_w-1:0]   cam_data,
    input  logic                        cam_valid,
    output logic                        gray_valid,
    output logic [vsp_pkg::gray_w-1:0]  gray,
    output logic [vsp_pkg::pix_w-1:0]   gray565,
    output logic                        disp_valid,
    output logic [vsp_pkg::pix_w-1:0]   disp_data,
    output logic                        udp_valid,
    output logic [vsp_pkg::pix_w-1:0]   udp_data,
    output logic                        fcnn_valid,
    output logic [vsp_pkg::gray_w-1:0]  fcnn_data
);

    localparam logic [vsp_pkg::coord_w-1:0] h_last = vsp_pkg::coord_w'(h_pixel - 1);

    pixel_if   px_bus ();
    roi_cfg_if cfg_bus ();

    logic [1:0]                  vsync_d, href_d, valid_d;
    logic [vsp_pkg::pix_w-1:0]   data_d1, data_d2;
    logic                        in_box, ink;
    logic [vsp_pkg::pix_w-1:0]   box_data;
    logic                        trail;        // line trailer cycle
    logic [vsp_pkg::coord_w-1:0] trail_line;

    rgb_to_gray u_rgb_to_gray (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .pix_valid  (cam_valid),
        .pix_data   (cam_data),
        .gray_valid (gray_valid),
        .gray       (gray),
        .gray565    (gray565)
    );

    // two stages so the raw pixel lines up with its gray value
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d <= '0;
            href_d  <= '0;
            valid_d <= '0;
        end else begin
            vsync_d <= {vsync_d[0], cam_vsync};
            href_d  <= {href_d[0], cam_href};
            valid_d <= {valid_d[0], cam_valid};
        end
    end

    always_ff @(posedge pclk) begin
        data_d1 <= cam_data;
        data_d2 <= data_d1;
    end

    raster_counter #(.h_pixel(h_pixel), .v_pixel(v_pixel)) u_raster_counter (
        .pclk  (pclk),
        .rst_n (rst_n),
        .vsync (vsync_d[1]),
        .href  (href_d[1]),
        .data  (data_d2),
        .valid (valid_d[1]),
        .px    (px_bus.src)
    );

    vsp_regs u_vsp_regs (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg_bus.drv)
    );

    roi_overlay u_roi_overlay (
        .px         (px_bus.snk),
        .cfg        (cfg_bus.rd),
        .gray       (gray),
        .gray_valid (gray_valid),
        .in_box     (in_box),
        .box_data   (box_data),
        .fcnn_valid (fcnn_valid),
        .fcnn_data  (fcnn_data)
    );

    digit_glyph #(.digit_x(digit_x), .digit_y(digit_y)) u_digit_glyph (
        .px  (px_bus.snk),
        .cfg (cfg_bus.rd),
        .ink (ink)
    );

    // square first, then digit, then camera
    assign disp_valid = px_bus.valid;

    always_comb begin
        if (in_box)
            disp_data = box_data;
        else if (ink)
            disp_data = vsp_pkg::ink565;
        else
            disp_data = px_bus.data;
    end

    // one trailer word after the last column of each line
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n)
            trail <= 1'b0;
        else
            trail <= px_bus.valid && (px_bus.h_index == h_last);
    end

    always_ff @(posedge pclk) begin
        trail_line <= px_bus.v_index;   // line index, caught before href drop moves it
    end

    assign udp_valid = disp_valid | trail;
    assign udp_data  = disp_valid ? disp_data
                                  : {{(vsp_pkg::pix_w - vsp_pkg::coord_w){1'b0}}, trail_line};

endmodule

/* tests/vsp_asserts.sv */
//****************************************
// vsp_asserts
// output strobe checks on the camera
// front end top level
//****************************************
`timescale 1ns/10ps

module vsp_asserts #(
    parameter int h_pixel = 640
) (
    input logic                          pclk,
    input logic                          rst_n,
    input logic                          gray_valid,
    input logic                          disp_valid,
    input logic                          udp_valid,
    input logic                          fcnn_valid,
    input logic                          at_marker,
    input logic [vsp_pkg::coord_w-1:0]   h_index
);

    int unsigned errors = 0;   // failure count, read by the testbench

    a_quiet_in_reset: assert property (@(posedge pclk)
        !rst_n |-> !(gray_valid | disp_valid | udp_valid | fcnn_valid))
        else begin $error("valid output high during reset"); errors++; end

    a_fcnn_source: assert property (@(posedge pclk) disable iff (!rst_n)
        fcnn_valid |-> disp_valid || at_marker)
        else begin $error("fcnn byte outside region and marker"); errors++; end

    // only extra udp word is the line trailer
    a_udp_trailer: assert property (@(posedge pclk) disable iff (!rst_n)
        udp_valid && !disp_valid |-> $past(disp_valid && h_index == h_pixel - 1))
        else begin $error("udp word without pixel or line end"); errors++; end

    a_no_x: assert property (@(posedge pclk)
        !$isunknown({gray_valid, disp_valid, udp_valid, fcnn_valid}))
        else begin $error("valid output unknown"); errors++; end

endmodule

bind video_stream_process vsp_asserts #(.h_pixel(h_pixel)) u_vsp_asserts (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .gray_valid (gray_valid),
    .disp_valid (disp_valid),
    .udp_valid  (udp_valid),
    .fcnn_valid (fcnn_valid),
    .at_marker  (u_roi_overlay.at_marker),
    .h_index    (px_bus.h_index)
);

/* tests/tb_video_stream_process.sv */
//****************************************
// tb_video_stream_process
// random frames through the camera front
// end, checked against a reference model
//****************************************
`timescale 1ns/10ps

module tb_video_stream_process;

    localparam int h_pix = 64;
    localparam int v_pix = 48;
    localparam int dig_x = 4;
    localparam int dig_y = 4;
    localparam int frames = 12;                           // reset, digits 9..0, then a write of 12
    localparam int limit = frames * (h_pix + 4) * v_pix * 4 + 2000;

    logic pclk = 1'b0;
    logic rst_n, cfg_wr, cam_vsync, cam_href, cam_valid;
    logic [1:0]  cfg_addr;
    logic [15:0] cfg_wdata, cam_data;
    logic gray_valid, disp_valid, udp_valid, fcnn_valid;
    logic [7:0]  gray, fcnn_data;
    logic [15:0] gray565, disp_data, udp_data;

    logic [31:0] seed;
    int          cyc = 0;
    int          m_rx, m_ry, m_dg;     // model of the settings
    logic [7:0]  m_th;
    logic [63:0] gray_q[$], disp_q[$], udp_q[$], fcnn_q[$];   // {cycle, word}
    int          fcnn_seen = 0;
    logic [7:0]  fcnn_last = 8'h00;

    video_stream_process #(.h_pixel(h_pix), .v_pixel(v_pix), .digit_x(dig_x), .digit_y(dig_y))
    u_video_stream_process (.*);

    always #5 pclk = ~pclk;
    always @(posedge pclk) cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], seed[0]};
            seed = lfsr_next(seed);   // one step per bit
        end
        return r;
    endfunction

    function automatic bit glyph_set(input int h, input int v);
        if (h < dig_x || h >= dig_x + vsp_pkg::glyph_w || v < dig_y || v >= dig_y + vsp_pkg::glyph_h)
            return 1'b0;
        return vsp_pkg::font_rows[m_dg][v - dig_y][7 - (h - dig_x)];
    endfunction

    task automatic tick();
        @(posedge pclk);
        #1;
    endtask

    // expected words for one pixel driven in this cycle
    task automatic model_pixel(input int h, input int v, input logic [15:0] d);
        logic [7:0]  r8, g8, b8, gy;
        logic [15:0] w;
        bit          in_int, in_sq;
        int          t;
        t = cyc + 2;
        r8 = {d[15:11], 3'b000};
        g8 = {d[10:5], 2'b00};
        b8 = {d[4:0], 3'b000};
        gy = 8'((77 * r8 + 150 * g8 + 29 * b8) >> 8);
        in_int = h >= m_rx && h < m_rx + vsp_pkg::roi_size &&
                 v >= m_ry && v < m_ry + vsp_pkg::roi_size;
        in_sq = h >= m_rx - 2 && h < m_rx + vsp_pkg::roi_size + 2 &&
                v >= m_ry - 2 && v < m_ry + vsp_pkg::roi_size + 2;
        if (in_int)
            w = (gy <= m_th) ? 16'hFFFF : 16'h0000;
        else if (in_sq)
            w = vsp_pkg::red565;
        else if (glyph_set(h, v))
            w = vsp_pkg::ink565;
        else
            w = d;
        gray_q.push_back({32'(t), 8'h00, gy[7:3], gy[7:2], gy[7:3], gy});
        disp_q.push_back({32'(t), 16'h0000, w});
        udp_q.push_back({32'(t), 16'h0000, w});
        if (in_int)
            fcnn_q.push_back({32'(t), 24'h0, (gy <= m_th) ? 8'hFF : 8'h00});
        else if (h == m_rx + 27 && v == m_ry + 28)
            fcnn_q.push_back({32'(t), 24'h0, vsp_pkg::fcnn_marker});
        if (h == h_pix - 1)
            udp_q.push_back({32'(t + 1), 22'h0, 10'(v)});   // line trailer
    endtask

    task automatic take_word(input int s, input string name, input logic [31:0] got);
        logic [63:0] e;
        int          n;
        case (s)
            0: n = gray_q.size();
            1: n = disp_q.size();
            2: n = udp_q.size();
            default: n = fcnn_q.size();
        endcase
        if (n == 0) begin
            abort_run({name, " strobe arrived with no word expected"});
        end else begin
            case (s)
                0: e = gray_q.pop_front();
                1: e = disp_q.pop_front();
                2: e = udp_q.pop_front();
                default: e = fcnn_q.pop_front();
            endcase
            check(name, got, e[31:0]);
            check({name, " cycle"}, cyc, e[63:32]);
        end
    endtask

    always @(negedge pclk) begin
        if (u_video_stream_process.u_vsp_asserts.errors != 0)
            abort_run("a bound assertion on the output strobes failed");
        if (rst_n) begin
            if (gray_valid) take_word(0, "gray565_gray", {8'h00, gray565, gray});
            if (disp_valid) take_word(1, "disp_data", {16'h0000, disp_data});
            if (udp_valid) take_word(2, "udp_data", {16'h0000, udp_data});
            if (fcnn_valid) begin
                take_word(3, "fcnn_data", {24'h0, fcnn_data});
                fcnn_seen++;
                fcnn_last = fcnn_data;
            end
        end
    end

    task automatic write_reg(input logic [1:0] a, input logic [15:0] d);
        cfg_wr = 1'b1;
        cfg_addr = a;
        cfg_wdata = d;
        tick();
        cfg_wr = 1'b0;
        case (a)
            vsp_pkg::reg_roi_x: m_rx = int'(d[9:0]);
            vsp_pkg::reg_roi_y: m_ry = int'(d[9:0]);
            vsp_pkg::reg_threshold: m_th = d[7:0];
            default: m_dg = (d > 16'd9) ? 9 : int'(d);
        endcase
    endtask

    task automatic run_frame(input int f);
        cam_vsync = 1'b1;
        tick();
        tick();
        if (f > 0) begin
            // square kept clear of the digit cell, except frame 1 covers it
            write_reg(vsp_pkg::reg_roi_x, (f == 1) ? 16'd6 : 16'(14 + rand_bits(6) % 21));
            write_reg(vsp_pkg::reg_roi_y, 16'(rand_bits(5) % 19));
            write_reg(vsp_pkg::reg_threshold, 16'(rand_bits(8)));
            write_reg(vsp_pkg::reg_digit, (f == frames - 1) ? 16'd12 : 16'(10 - f));
        end
        tick();
        cam_vsync = 1'b0;
        tick();
        for (int v = 0; v < v_pix; v++) begin
            cam_href = 1'b1;
            for (int h = 0; h < h_pix; h++) begin
                if (rand_bits(1)) tick();   // gap before this pixel
                cam_data = rand_bits(16);
                cam_valid = 1'b1;
                model_pixel(h, v, cam_data);
                tick();
                cam_valid = 1'b0;
            end
            cam_href = 1'b0;
            tick();
            tick();
        end
        repeat (6) tick();
        check("fcnn_count", fcnn_seen, 785);
        check("fcnn_last", {24'h0, fcnn_last}, {24'h0, vsp_pkg::fcnn_marker});
        fcnn_seen = 0;
    endtask

    initial begin
        repeat (limit) @(posedge pclk);
        abort_run("watchdog expired, the frames did not finish in time");
    end

    initial begin
        seed = 32'h5119;
        rst_n = 1'b0;
        cfg_wr = 1'b0;
        cfg_addr = 2'd0;
        cfg_wdata = 16'h0000;
        cam_vsync = 1'b0;
        cam_href = 1'b0;
        cam_valid = 1'b0;
        cam_data = 16'h0000;
        m_rx = int'(vsp_pkg::rst_roi_x);
        m_ry = int'(vsp_pkg::rst_roi_y);
        m_th = vsp_pkg::rst_threshold;
        m_dg = int'(vsp_pkg::rst_digit);
        repeat (4) @(posedge pclk);
        #1 rst_n = 1'b1;
        for (int f = 0; f < frames; f++)
            run_frame(f);
        repeat (4) tick();
        if (gray_q.size() + disp_q.size() + udp_q.size() + fcnn_q.size() != 0)
            abort_run("expected words never arrived from the DUT");
        else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* vsp.f */
logic/vsp_pkg.sv
logic/pixel_if.sv
logic/roi_cfg_if.sv
logic/rgb_to_gray.sv
logic/raster_counter.sv
logic/vsp_regs.sv
logic/roi_overlay.sv
logic/digit_glyph.sv
logic/video_stream_process.sv
tests/vsp_asserts.sv
tests/tb_video_stream_process.sv
